//--- files.f
+incdir+.
mem_pkg.sv
dcache_array.sv
dcache_ctrl.sv
mem_stage.sv
mem_access_unit.sv
tb_mem_model.sv
tb_mem_access_unit.sv

//--- tb_mem_access_unit.sv
// self-checking testbench; addresses stay below 4 KB because the memory model decodes 1024 words
`timescale 1ns/1ps

module tb_mem_access_unit;

    import mem_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int RST_CYCLES = 8;
    localparam int N_OPS      = 16;

    logic     clk;
    logic     rst_n;
    word_t    alu_result_in;
    word_t    mem_wdata_in;
    logic     memrd_in;
    logic     memwr_in;
    word_t    pc_plus_4_in;
    reg_idx_t rd_in;
    logic     mem2reg_in;
    logic     regwr_in;
    word_t    alu_result_out;
    word_t    mem_dat;
    word_t    pc_plus_4_out;
    reg_idx_t rd_out;
    logic     mem2reg_out;
    logic     regwr_out;
    logic     stall;
    logic     mem_req;
    logic     mem_we;
    waddr_t   mem_addr;
    word_t    mem_wdata;
    word_t    mem_rdata;
    logic     mem_ready;

    // stimulus side
    logic     exp_hit;
    word_t    pc_next;

    // checker state, sampled at negedge
    logic     armed;
    logic     req_seen;
    logic     prev_stall;
    logic     prev_req;
    logic     prev_ready;
    logic     prev_we;
    waddr_t   prev_addr;
    word_t    prev_wdata;
    word_t    exp_alu;
    word_t    exp_pc;
    reg_idx_t exp_rd;
    logic     exp_m2r;
    logic     exp_rw;
    logic     exp_load;
    waddr_t   exp_word;

    mem_access_unit u_mem_access_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .alu_result_in  (alu_result_in),
        .mem_wdata_in   (mem_wdata_in),
        .memrd_in       (memrd_in),
        .memwr_in       (memwr_in),
        .pc_plus_4_in   (pc_plus_4_in),
        .rd_in          (rd_in),
        .mem2reg_in     (mem2reg_in),
        .regwr_in       (regwr_in),
        .alu_result_out (alu_result_out),
        .mem_dat        (mem_dat),
        .pc_plus_4_out  (pc_plus_4_out),
        .rd_out         (rd_out),
        .mem2reg_out    (mem2reg_out),
        .regwr_out      (regwr_out),
        .stall          (stall),
        .mem_req        (mem_req),
        .mem_we         (mem_we),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_rdata      (mem_rdata),
        .mem_ready      (mem_ready)
    );

    tb_mem_model u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        assert (got === want)
            else stop_with_error($sformatf("ERR %s: got 0x%h, expected 0x%h", name, got, want));
    endtask

    // present one op and hold it until the stall drops
    task automatic issue_op(input word_t alu, input word_t wdata, input logic rd_en,
                            input logic wr_en, input reg_idx_t rd, input logic m2r,
                            input logic rw, input logic hit);
        @(posedge clk);
        alu_result_in <= alu;
        mem_wdata_in  <= wdata;
        memrd_in      <= rd_en;
        memwr_in      <= wr_en;
        pc_plus_4_in  <= pc_next;
        rd_in         <= rd;
        mem2reg_in    <= m2r;
        regwr_in      <= rw;
        exp_hit       <= hit;
        pc_next = pc_next + 32'd4;
        @(negedge clk);
        while (stall) begin
            @(negedge clk);
        end
    endtask

    task automatic alu_op(input word_t result, input reg_idx_t rd, input logic rw);
        issue_op(result, 32'h0bad_0000, 1'b0, 1'b0, rd, 1'b0, rw, 1'b0);
    endtask

    task automatic load_word(input word_t addr, input reg_idx_t rd, input logic hit);
        issue_op(addr, 32'hffff_ffff, 1'b1, 1'b0, rd, 1'b1, 1'b1, hit);
    endtask

    task automatic store_word(input word_t addr, input word_t data);
        issue_op(addr, data, 1'b0, 1'b1, 5'd0, 1'b0, 1'b0, 1'b0);
    endtask

    always @(negedge clk) begin
        if (!rst_n) begin
            expect_equal("stall", stall, 0);
            expect_equal("mem_req", mem_req, 0);
            expect_equal("mem_we", mem_we, 0);
            expect_equal("regwr_out", regwr_out, 0);
            expect_equal("mem2reg_out", mem2reg_out, 0);
            expect_equal("alu_result_out", alu_result_out, 0);
            expect_equal("mem_dat", mem_dat, 0);
            expect_equal("pc_plus_4_out", pc_plus_4_out, 0);
            expect_equal("rd_out", rd_out, 0);
            armed    = 1'b0;
            req_seen = 1'b0;
        end else begin
            if (armed) begin
                // MEM/WB fields show the last op that left with stall low
                expect_equal("alu_result_out", alu_result_out, exp_alu);
                expect_equal("pc_plus_4_out", pc_plus_4_out, exp_pc);
                expect_equal("rd_out", rd_out, exp_rd);
                expect_equal("mem2reg_out", mem2reg_out, exp_m2r);
                expect_equal("regwr_out", regwr_out, exp_rw);
                if (!prev_stall && exp_load) begin
                    expect_equal("mem_dat", mem_dat, u_mem.shadow[exp_word[9:0]]);
                end
                // request is held until ready
                if (prev_req && !prev_ready) begin
                    assert (mem_req) else stop_with_error("mem_req dropped before mem_ready");
                    expect_equal("mem_we", mem_we, prev_we);
                    expect_equal("mem_addr", mem_addr, prev_addr);
                    expect_equal("mem_wdata", mem_wdata, prev_wdata);
                end
                if (prev_ready) begin
                    assert (!mem_req)
                        else stop_with_error("mem_req still high the cycle after mem_ready");
                end
                // first cycle of a new op
                if (!prev_stall && memrd_in) begin
                    if (exp_hit) begin
                        assert (!stall && !mem_req)
                            else stop_with_error("load expected to hit stalled or went to memory");
                    end else begin
                        assert (stall) else stop_with_error("load expected to miss did not stall");
                    end
                end
                if (!prev_stall && memwr_in) begin
                    assert (stall) else stop_with_error("store did not stall the pipeline");
                end
            end
            if (mem_req) begin
                req_seen = 1'b1;
                expect_equal("mem_addr", mem_addr, alu_result_in[31:2]);
                expect_equal("mem_we", mem_we, memwr_in);
                if (memwr_in) begin
                    expect_equal("mem_wdata", mem_wdata, mem_wdata_in);
                end
            end
            if (!memrd_in && !memwr_in) begin
                assert (!stall && !mem_req)
                    else stop_with_error("op without memory access raised stall or mem_req");
            end
            // op retires at the next edge
            if (!stall) begin
                if (memwr_in || (memrd_in && !exp_hit)) begin
                    assert (req_seen)
                        else stop_with_error("memory access finished without a memory request");
                end
                req_seen = 1'b0;
                exp_alu  = alu_result_in;
                exp_pc   = pc_plus_4_in;
                exp_rd   = rd_in;
                exp_m2r  = mem2reg_in;
                exp_rw   = regwr_in;
                exp_load = memrd_in;
                exp_word = alu_result_in[31:2];
            end
            prev_stall = stall;
            prev_req   = mem_req;
            prev_ready = mem_ready;
            prev_we    = mem_we;
            prev_addr  = mem_addr;
            prev_wdata = mem_wdata;
            armed      = 1'b1;
        end
    end

    // watchdog, ten cycles per op plus reset
    initial begin
        #((RST_CYCLES + N_OPS * 10) * CLK_PERIOD);
        stop_with_error("watchdog expired before all operations finished");
    end

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        alu_result_in = '0;
        mem_wdata_in  = '0;
        memrd_in      = 1'b0;
        memwr_in      = 1'b0;
        pc_plus_4_in  = '0;
        rd_in         = '0;
        mem2reg_in    = 1'b0;
        regwr_in      = 1'b0;
        exp_hit       = 1'b0;
        pc_next       = 32'h0000_0104;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        alu_op(32'h1234_5678, 5'd3, 1'b1);
        alu_op(32'hdead_beef, 5'd31, 1'b0);
        // cold miss, then hits on the same word
        load_word(32'h0000_0040, 5'd5, 1'b0);
        load_word(32'h0000_0040, 5'd6, 1'b1);
        load_word(32'h0000_0041, 5'd7, 1'b1);
        // same index with a new tag evicts the line
        load_word(32'h0000_0440, 5'd8, 1'b0);
        load_word(32'h0000_0040, 5'd9, 1'b0);
        // store hit updates the line
        store_word(32'h0000_0040, 32'hc0de_1111);
        load_word(32'h0000_0040, 5'd10, 1'b1);
        // store miss leaves the cache alone
        store_word(32'h0000_0800, 32'h5a5a_a5a5);
        load_word(32'h0000_0800, 5'd11, 1'b0);
        load_word(32'h0000_0800, 5'd12, 1'b1);
        load_word(32'h0000_0ffc, 5'd13, 1'b0);
        store_word(32'h0000_0ffc, 32'h0bad_f00d);
        load_word(32'h0000_0ffc, 5'd14, 1'b1);
        // idle slot so the last load is checked
        alu_op(32'h0000_0000, 5'd0, 1'b0);
        repeat (2) @(posedge clk);
        $display("Test OK");
        $finish;
    end

endmodule

//--- tb_mem_model.sv
// main memory model; word addresses wrap at 1024, ready comes 1 to 4 cycles after a request
`timescale 1ns/1ps

module tb_mem_model (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            mem_req,
    input  logic            mem_we,
    input  mem_pkg::waddr_t mem_addr,
    input  mem_pkg::word_t  mem_wdata,
    output mem_pkg::word_t  mem_rdata,
    output logic            mem_ready
);

    import mem_pkg::*;

    localparam int          MEM_WORDS = 1024;
    localparam logic [31:0] LFSR_SEED = 32'h4d06_7912;

    // memory contents and reference for load data
    word_t       shadow [MEM_WORDS];
    logic [31:0] lfsr;
    logic [31:0] lfsr_a;
    logic [31:0] lfsr_b;
    logic [1:0]  wait_cnt;
    logic        busy;

    // fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step for each latency bit
    assign lfsr_a = lfsr_next(lfsr);
    assign lfsr_b = lfsr_next(lfsr_a);

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // fill pattern built from the full word address
            for (int i = 0; i < MEM_WORDS; i++) begin
                shadow[i] <= (word_t'(i) << 2) ^ (word_t'(i) << 21) ^ 32'h9e37_79b9;
            end
            lfsr      <= LFSR_SEED;
            wait_cnt  <= '0;
            busy      <= 1'b0;
            mem_ready <= 1'b0;
            mem_rdata <= '0;
        end else begin
            mem_ready <= 1'b0;
            if (mem_req && !busy && !mem_ready) begin
                // new request picks its latency
                busy     <= 1'b1;
                wait_cnt <= {lfsr_a[0], lfsr_b[0]};
                lfsr     <= lfsr_b;
            end else if (busy) begin
                wait_cnt <= wait_cnt - 2'd1;
                if (wait_cnt == 2'd0) begin
                    busy      <= 1'b0;
                    mem_ready <= 1'b1;
                    if (mem_we) begin
                        shadow[mem_addr[9:0]] <= mem_wdata;
                    end else begin
                        mem_rdata <= shadow[mem_addr[9:0]];
                    end
                end
            end
        end
    end

endmodule

//--- mem_access_unit.sv
// upstream EX/MEM must hold its outputs while stall is high; memory ready must pulse only under req
`timescale 1ns/1ps
`include "mem_cfg.svh"

module mem_access_unit (
    input  logic              clk,
    input  logic              rst_n,
    // EX/MEM fields
    input  mem_pkg::word_t    alu_result_in,
    input  mem_pkg::word_t    mem_wdata_in,
    input  logic              memrd_in,
    input  logic              memwr_in,
    input  mem_pkg::word_t    pc_plus_4_in,
    input  mem_pkg::reg_idx_t rd_in,
    input  logic              mem2reg_in,
    input  logic              regwr_in,
    // MEM/WB fields
    output mem_pkg::word_t    alu_result_out,
    output mem_pkg::word_t    mem_dat,
    output mem_pkg::word_t    pc_plus_4_out,
    output mem_pkg::reg_idx_t rd_out,
    output logic              mem2reg_out,
    output logic              regwr_out,
    output logic              stall,
    // main memory
    output logic              mem_req,
    output logic              mem_we,
    output mem_pkg::waddr_t   mem_addr,
    output mem_pkg::word_t    mem_wdata,
    input  mem_pkg::word_t    mem_rdata,
    input  logic              mem_ready
);

    import mem_pkg::*;

    // stage to controller
    logic   dc_ren;
    logic   dc_wen;
    waddr_t dc_addr;
    word_t  dc_wdata;
    word_t  dc_rdata;

    // controller and array
    logic   hit;
    word_t  rd_data;
    logic   arr_we;
    waddr_t arr_addr;
    word_t  arr_wdata;

    mem_stage u_mem_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .alu_result_in  (alu_result_in),
        .mem_wdata_in   (mem_wdata_in),
        .memrd_in       (memrd_in),
        .memwr_in       (memwr_in),
        .pc_plus_4_in   (pc_plus_4_in),
        .rd_in          (rd_in),
        .mem2reg_in     (mem2reg_in),
        .regwr_in       (regwr_in),
        .alu_result_out (alu_result_out),
        .mem_dat        (mem_dat),
        .pc_plus_4_out  (pc_plus_4_out),
        .rd_out         (rd_out),
        .mem2reg_out    (mem2reg_out),
        .regwr_out      (regwr_out),
        .dc_ren         (dc_ren),
        .dc_wen         (dc_wen),
        .dc_addr        (dc_addr),
        .dc_wdata       (dc_wdata),
        .stall          (stall),
        .dc_rdata       (dc_rdata)
    );

    dcache_ctrl u_dcache_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .dc_ren    (dc_ren),
        .dc_wen    (dc_wen),
        .dc_addr   (dc_addr),
        .dc_wdata  (dc_wdata),
        .hit       (hit),
        .rd_data   (rd_data),
        .stall     (stall),
        .dc_rdata  (dc_rdata),
        .arr_we    (arr_we),
        .arr_addr  (arr_addr),
        .arr_wdata (arr_wdata),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

    // lookup always follows the current request address
    dcache_array u_dcache_array (
        .clk         (clk),
        .rst_n       (rst_n),
        .lookup_addr (dc_addr),
        .arr_we      (arr_we),
        .arr_addr    (arr_addr),
        .arr_wdata   (arr_wdata),
        .hit         (hit),
        .rd_data     (rd_data)
    );

endmodule

//--- mem_stage.sv
// full-word access only; cache request is driven straight from EX/MEM, mem_dat samples every cycle
`timescale 1ns/1ps
`include "mem_cfg.svh"

module mem_stage (
    input  logic              clk,
    input  logic              rst_n,
    // from the EX/MEM register
    input  mem_pkg::word_t    alu_result_in,
    input  mem_pkg::word_t    mem_wdata_in,
    input  logic              memrd_in,
    input  logic              memwr_in,
    input  mem_pkg::word_t    pc_plus_4_in,
    input  mem_pkg::reg_idx_t rd_in,
    input  logic              mem2reg_in,
    input  logic              regwr_in,
    // MEM/WB register outputs
    output mem_pkg::word_t    alu_result_out,
    output mem_pkg::word_t    mem_dat,
    output mem_pkg::word_t    pc_plus_4_out,
    output mem_pkg::reg_idx_t rd_out,
    output logic              mem2reg_out,
    output logic              regwr_out,
    // data cache request, not registered
    output logic              dc_ren,
    output logic              dc_wen,
    output mem_pkg::waddr_t   dc_addr,
    output mem_pkg::word_t    dc_wdata,
    input  logic              stall,
    input  mem_pkg::word_t    dc_rdata
);

    import mem_pkg::*;

    word_t    alu_result_nxt;
    word_t    pc_plus_4_nxt;
    reg_idx_t rd_nxt;
    logic     mem2reg_nxt;
    logic     regwr_nxt;

    // cache request, byte offset dropped
    assign dc_ren   = memrd_in;
    assign dc_wen   = memwr_in;
    assign dc_addr  = alu_result_in[`MEM_WORD_W-1:2];
    assign dc_wdata = mem_wdata_in;

    // hold every field except the load data while the cache stalls
    always_comb begin
        alu_result_nxt = stall ? alu_result_out : alu_result_in;
        pc_plus_4_nxt  = stall ? pc_plus_4_out  : pc_plus_4_in;
        rd_nxt         = stall ? rd_out         : rd_in;
        mem2reg_nxt    = stall ? mem2reg_out    : mem2reg_in;
        regwr_nxt      = stall ? regwr_out      : regwr_in;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_result_out <= `MEM_FIELD_RST;
            mem_dat        <= `MEM_FIELD_RST;
            pc_plus_4_out  <= `MEM_FIELD_RST;
            rd_out         <= `MEM_FIELD_RST;
            mem2reg_out    <= 1'b0;
            regwr_out      <= 1'b0;
        end else begin
            alu_result_out <= alu_result_nxt;
            // load data settles on the cycle stall falls
            mem_dat        <= dc_rdata;
            pc_plus_4_out  <= pc_plus_4_nxt;
            rd_out         <= rd_nxt;
            mem2reg_out    <= mem2reg_nxt;
            regwr_out      <= regwr_nxt;
        end
    end

endmodule

//--- dcache_ctrl.sv
// write-through, no write-allocate; upstream must hold dc_* inputs while stall is high
`timescale 1ns/1ps
`include "mem_cfg.svh"

module dcache_ctrl (
    input  logic            clk,
    input  logic            rst_n,
    // request from the MEM stage
    input  logic            dc_ren,
    input  logic            dc_wen,
    input  mem_pkg::waddr_t dc_addr,
    input  mem_pkg::word_t  dc_wdata,
    // lookup result from the array
    input  logic            hit,
    input  mem_pkg::word_t  rd_data,
    // back to the MEM stage
    output logic            stall,
    output mem_pkg::word_t  dc_rdata,
    // array write port
    output logic            arr_we,
    output mem_pkg::waddr_t arr_addr,
    output mem_pkg::word_t  arr_wdata,
    // main memory port
    output logic            mem_req,
    output logic            mem_we,
    output mem_pkg::waddr_t mem_addr,
    output mem_pkg::word_t  mem_wdata,
    input  mem_pkg::word_t  mem_rdata,
    input  logic            mem_ready
);

    import mem_pkg::*;

    dc_state_t state;
    dc_state_t state_nxt;

    // address and store data of the outstanding memory access
    waddr_t req_addr;
    word_t  req_wdata;

    logic read_miss;
    logic start_req;

    assign read_miss = dc_ren && !hit;
    assign start_req = (state == DC_IDLE) && (dc_wen || read_miss);

    // next state and stall
    always_comb begin
        state_nxt = state;
        stall     = 1'b0;
        case (state)
            DC_IDLE: begin
                // stores take priority over loads
                if (dc_wen) begin
                    stall     = 1'b1;
                    state_nxt = DC_WRITE;
                end else if (read_miss) begin
                    stall     = 1'b1;
                    state_nxt = DC_REFILL;
                end
            end
            DC_REFILL: begin
                stall = 1'b1;
                if (mem_ready) begin
                    // line is written now, next cycle hits
                    state_nxt = DC_IDLE;
                end
            end
            DC_WRITE: begin
                stall = 1'b1;
                if (mem_ready) begin
                    state_nxt = DC_RELEASE;
                end
            end
            DC_RELEASE: begin
                // one free cycle so the held store retires
                state_nxt = DC_IDLE;
            end
            default: begin
                state_nxt = DC_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= DC_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // capture the request when leaving idle
    always_ff @(posedge clk) begin
        if (start_req) begin
            req_addr  <= dc_addr;
            req_wdata <= dc_wdata;
        end
    end

    // refill fills the line; a store only updates a line it hits
    always_comb begin
        arr_we    = 1'b0;
        arr_addr  = req_addr;
        arr_wdata = req_wdata;
        if (state == DC_REFILL && mem_ready) begin
            arr_we    = 1'b1;
            arr_wdata = mem_rdata;
        end else if (state == DC_WRITE && mem_ready && hit) begin
            arr_we = 1'b1;
        end
    end

    // memory request is held by the state, drops the cycle after ready
    assign mem_req   = (state == DC_REFILL) || (state == DC_WRITE);
    assign mem_we    = (state == DC_WRITE);
    assign mem_addr  = req_addr;
    assign mem_wdata = req_wdata;

    // only hit data is forwarded
    assign dc_rdata = hit ? rd_data : '0;

endmodule

//--- dcache_array.sv
// direct-mapped, one word per line; combinational lookup, tag and data are X until written
`timescale 1ns/1ps
`include "mem_cfg.svh"

module dcache_array (
    input  logic            clk,
    input  logic            rst_n,
    // lookup side
    input  mem_pkg::waddr_t lookup_addr,
    // line write port
    input  logic            arr_we,
    input  mem_pkg::waddr_t arr_addr,
    input  mem_pkg::word_t  arr_wdata,
    // lookup result
    output logic            hit,
    output mem_pkg::word_t  rd_data
);

    import mem_pkg::*;

    localparam int IDX_W = `MEM_CACHE_IDX_W;
    localparam int TAG_W = `MEM_ADDR_W - `MEM_CACHE_IDX_W;
    localparam int LINES = 1 << IDX_W;

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [TAG_W-1:0] tag_t;

    // storage
    logic [LINES-1:0] valid;
    tag_t             tag_mem  [LINES];
    word_t            data_mem [LINES];

    // address split for both ports
    idx_t lk_idx;
    tag_t lk_tag;
    idx_t wr_idx;
    tag_t wr_tag;

    assign lk_idx = lookup_addr[IDX_W-1:0];
    assign lk_tag = lookup_addr[`MEM_ADDR_W-1:IDX_W];
    assign wr_idx = arr_addr[IDX_W-1:0];
    assign wr_tag = arr_addr[`MEM_ADDR_W-1:IDX_W];

    // index, compare tag, qualify with valid
    assign hit     = valid[lk_idx] && (tag_mem[lk_idx] == lk_tag);
    assign rd_data = data_mem[lk_idx];

    // a line write marks its index valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (arr_we) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    // tag and data follow the write port
    always_ff @(posedge clk) begin
        if (arr_we) begin
            tag_mem[wr_idx]  <= wr_tag;
            data_mem[wr_idx] <= arr_wdata;
        end
    end

endmodule

//--- mem_pkg.sv
// types only; widths come from mem_cfg.svh, so that header must be on the include path
`include "mem_cfg.svh"

package mem_pkg;

    // data words and ALU results
    typedef logic [`MEM_WORD_W-1:0] word_t;

    // word address, byte offset removed
    typedef logic [`MEM_ADDR_W-1:0] waddr_t;

    // destination register index
    typedef logic [`MEM_REG_IDX_W-1:0] reg_idx_t;

    // cache controller states
    // idle serves hits, refill waits on a read miss,
    // write waits on a store, release lets the store retire
    typedef enum logic [1:0] {
        DC_IDLE    = 2'd0,
        DC_REFILL  = 2'd1,
        DC_WRITE   = 2'd2,
        DC_RELEASE = 2'd3
    } dc_state_t;

endpackage

//--- mem_cfg.svh
// widths assume a 32-bit word machine with word-aligned access only; cache index must be below 30
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// data path word width
`define MEM_WORD_W 32

// destination register index, 32 registers
`define MEM_REG_IDX_W 5

// direct-mapped cache index, 64 lines of one word
`define MEM_CACHE_IDX_W 6

// word address, the byte offset bits are dropped
`define MEM_ADDR_W 30

// value loaded into the MEM/WB fields at reset
`define MEM_FIELD_RST '0

`endif
